// ==== logic/fx3_loopback_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module fx3_loopback_top #(
    parameter int BURST_WORDS     = 4096,
    parameter int FIFO_DEPTH_LOG2 = 12
) (
    input  logic                 usb_clk,
    input  logic                 reset_,
    input  fx3_pkg::gpif_flags_t flags_i,
    input  fx3_pkg::gpif_word_t  data_i,
    output fx3_pkg::gpif_ctrl_t  ctrl_o,
    output fx3_pkg::gpif_word_t  data_o,
    output logic                 data_oe_o
);
    import fx3_pkg::*;

    gpif_flags_t              flags_q;
    logic                     push;
    gpif_word_t               push_word;
    logic                     pop;
    gpif_word_t               pop_word;
    logic [FIFO_DEPTH_LOG2:0] count;
    xfer_state_t              state;
    logic                     rd_issue;
    logic                     rd_pin_q;

    // input side
    gpif_capture u_capture (
        .usb_clk     (usb_clk),
        .reset_      (reset_),
        .flags_i     (flags_i),
        .data_i      (data_i),
        .rd_pin_q_i  (rd_pin_q),
        .flags_q_o   (flags_q),
        .push_o      (push),
        .push_word_o (push_word)
    );

    word_fifo #(
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) u_fifo (
        .usb_clk     (usb_clk),
        .reset_      (reset_),
        .push_i      (push),
        .push_word_i (push_word),
        .pop_i       (pop),
        .pop_word_o  (pop_word),
        .count_o     (count)
    );

    transfer_sequencer #(
        .BURST_WORDS     (BURST_WORDS),
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) u_sequencer (
        .usb_clk    (usb_clk),
        .reset_     (reset_),
        .flags_q_i  (flags_q),
        .count_i    (count),
        .state_o    (state),
        .rd_issue_o (rd_issue),
        .pop_o      (pop)
    );

    // output side, every pin leaves from a flop here
    gpif_drive u_drive (
        .usb_clk    (usb_clk),
        .reset_     (reset_),
        .state_i    (state),
        .rd_issue_i (rd_issue),
        .pop_i      (pop),
        .pop_word_i (pop_word),
        .ctrl_o     (ctrl_o),
        .data_o     (data_o),
        .data_oe_o  (data_oe_o),
        .rd_pin_q_o (rd_pin_q)
    );

endmodule

`default_nettype wire

// ==== logic/fx3_pkg.sv ====
`default_nettype none

package fx3_pkg;

    // width of one slave FIFO bus word
    localparam int WORD_W = 16;

    typedef logic [WORD_W-1:0] gpif_word_t;

    // FX3 socket address pins A1:A0
    localparam int FIFO_ADDR_W = 2;

    localparam logic [FIFO_ADDR_W-1:0] ADDR_STREAM_OUT = 2'b11;
    localparam logic [FIFO_ADDR_W-1:0] ADDR_STREAM_IN  = 2'b00;
    localparam logic [FIFO_ADDR_W-1:0] ADDR_IDLE       = 2'b10;

    // cycles from slrd_n low to the word on the bus
    localparam int RD_LATENCY = 2;

    // a/b: stream-in side, c/d: stream-out side
    typedef struct packed {
        logic flag_a;
        logic flag_b;
        logic flag_c;
        logic flag_d;
    } gpif_flags_t;

    // chip controls, all strobes active low
    typedef struct packed {
        logic                   slcs_n;
        logic                   slrd_n;
        logic                   sloe_n;
        logic                   slwr_n;
        logic [FIFO_ADDR_W-1:0] addr;
    } gpif_ctrl_t;

    typedef enum logic [1:0] {
        XFER_IDLE  = 2'd0,
        XFER_READ  = 2'd1,
        XFER_FILL  = 2'd2,
        XFER_WRITE = 2'd3
    } xfer_state_t;

endpackage

`default_nettype wire

// ==== logic/gpif_capture.sv ====
`timescale 1ns/100ps
`default_nettype none

module gpif_capture (
    input  logic                 usb_clk,
    input  logic                 reset_,
    input  fx3_pkg::gpif_flags_t flags_i,
    input  fx3_pkg::gpif_word_t  data_i,
    input  logic                 rd_pin_q_i,
    output fx3_pkg::gpif_flags_t flags_q_o,
    output logic                 push_o,
    output fx3_pkg::gpif_word_t  push_word_o
);
    import fx3_pkg::*;

    gpif_flags_t           flags_q;
    gpif_word_t            data_q;
    logic [RD_LATENCY-1:0] rd_pipe;
    logic                  push_q;

    // flags are asynchronous to our decisions, take them through one flop
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            flags_q <= '0;
        end else begin
            flags_q <= flags_i;
        end
    end

    // bus word sampled every cycle, only some are kept
    always_ff @(posedge usb_clk) begin
        data_q <= data_i;
    end

    // read strobe as seen on the pin, delayed until its word is on data_i
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            rd_pipe <= '0;
        end else begin
            rd_pipe[0] <= ~rd_pin_q_i;
            for (int i = 1; i < RD_LATENCY; i++) begin
                rd_pipe[i] <= rd_pipe[i-1];
            end
        end
    end

    // one more stage so the push lines up with data_q
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            push_q <= 1'b0;
        end else begin
            push_q <= rd_pipe[RD_LATENCY-1];
        end
    end

    // each slrd_n-low cycle yields exactly one push, even back to back
    assign push_o      = push_q;
    assign push_word_o = data_q;
    assign flags_q_o   = flags_q;

endmodule

`default_nettype wire

// ==== logic/gpif_drive.sv ====
`timescale 1ns/100ps
`default_nettype none

module gpif_drive (
    input  logic                 usb_clk,
    input  logic                 reset_,
    input  fx3_pkg::xfer_state_t state_i,
    input  logic                 rd_issue_i,
    input  logic                 pop_i,
    input  fx3_pkg::gpif_word_t  pop_word_i,
    output fx3_pkg::gpif_ctrl_t  ctrl_o,
    output fx3_pkg::gpif_word_t  data_o,
    output logic                 data_oe_o,
    output logic                 rd_pin_q_o
);
    import fx3_pkg::*;

    gpif_ctrl_t ctrl_d;
    gpif_ctrl_t ctrl_q;
    logic       data_oe_q;
    gpif_word_t data_q;

    always_comb begin
        ctrl_d.slcs_n = (state_i == XFER_IDLE);
        ctrl_d.slrd_n = ~rd_issue_i;
        // keep sloe_n low until the in-flight read words have landed
        ctrl_d.sloe_n = ~(rd_issue_i || (state_i == XFER_FILL));
        ctrl_d.slwr_n = ~pop_i;
        case (state_i)
            XFER_READ,
            XFER_FILL:  ctrl_d.addr = ADDR_STREAM_OUT;
            XFER_WRITE: ctrl_d.addr = ADDR_STREAM_IN;
            default:    ctrl_d.addr = ADDR_IDLE;
        endcase
    end

    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            ctrl_q.slcs_n <= 1'b1;
            ctrl_q.slrd_n <= 1'b1;
            ctrl_q.sloe_n <= 1'b1;
            ctrl_q.slwr_n <= 1'b1;
            ctrl_q.addr   <= ADDR_IDLE;
            data_oe_q     <= 1'b0;
        end else begin
            ctrl_q    <= ctrl_d;
            data_oe_q <= pop_i;
        end
    end

    // write data leaves on the same edge as its slwr_n
    always_ff @(posedge usb_clk) begin
        if (pop_i) begin
            data_q <= pop_word_i;
        end
    end

    assign ctrl_o     = ctrl_q;
    assign data_o     = data_q;
    assign data_oe_o  = data_oe_q;
    assign rd_pin_q_o = ctrl_q.slrd_n;

endmodule

`default_nettype wire

// ==== logic/transfer_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module transfer_sequencer #(
    parameter int BURST_WORDS     = 4096,
    parameter int FIFO_DEPTH_LOG2 = 12
) (
    input  logic                     usb_clk,
    input  logic                     reset_,
    input  fx3_pkg::gpif_flags_t     flags_q_i,
    input  logic [FIFO_DEPTH_LOG2:0] count_i,
    output fx3_pkg::xfer_state_t     state_o,
    output logic                     rd_issue_o,
    output logic                     pop_o
);
    import fx3_pkg::*;

    localparam int CNT_W = $clog2(BURST_WORDS + 1);

    localparam logic [CNT_W-1:0]           LAST_WORD  = CNT_W'(BURST_WORDS - 1);
    localparam logic [FIFO_DEPTH_LOG2:0]   FULL_COUNT = (FIFO_DEPTH_LOG2 + 1)'(BURST_WORDS);

    xfer_state_t      state_q;
    xfer_state_t      state_d;
    logic [CNT_W-1:0] word_cnt_q;
    logic [CNT_W-1:0] word_cnt_d;
    logic             rd_issue;
    logic             pop;
    logic             out_ready;
    logic             in_ready;

    // stream-out socket has data / stream-in socket has room
    assign out_ready = flags_q_i.flag_c && flags_q_i.flag_d;
    assign in_ready  = flags_q_i.flag_a && flags_q_i.flag_b;

    always_comb begin
        state_d    = state_q;
        word_cnt_d = word_cnt_q;
        rd_issue   = 1'b0;
        pop        = 1'b0;

        case (state_q)
            XFER_IDLE: begin
                word_cnt_d = '0;
                if (out_ready) begin
                    state_d = XFER_READ;
                end
            end

            // one read per cycle, no pauses inside the burst
            XFER_READ: begin
                rd_issue = 1'b1;
                if (word_cnt_q == LAST_WORD) begin
                    state_d    = XFER_FILL;
                    word_cnt_d = '0;
                end else begin
                    word_cnt_d = word_cnt_q + CNT_W'(1);
                end
            end

            // reads still in flight, wait for the last push
            XFER_FILL: begin
                if (count_i == FULL_COUNT) begin
                    state_d = XFER_WRITE;
                end
            end

            // flag_b low holds off further pops
            XFER_WRITE: begin
                pop = in_ready && (count_i != '0);
                if (pop) begin
                    if (word_cnt_q == LAST_WORD) begin
                        state_d    = XFER_IDLE;
                        word_cnt_d = '0;
                    end else begin
                        word_cnt_d = word_cnt_q + CNT_W'(1);
                    end
                end
            end

            default: begin
                state_d    = XFER_IDLE;
                word_cnt_d = '0;
            end
        endcase
    end

    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            state_q    <= XFER_IDLE;
            word_cnt_q <= '0;
        end else begin
            state_q    <= state_d;
            word_cnt_q <= word_cnt_d;
        end
    end

    assign state_o    = state_q;
    assign rd_issue_o = rd_issue;
    assign pop_o      = pop;

endmodule

`default_nettype wire

// ==== logic/word_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module word_fifo #(
    parameter int FIFO_DEPTH_LOG2 = 12
) (
    input  logic                      usb_clk,
    input  logic                      reset_,
    input  logic                      push_i,
    input  fx3_pkg::gpif_word_t       push_word_i,
    input  logic                      pop_i,
    output fx3_pkg::gpif_word_t       pop_word_o,
    output logic [FIFO_DEPTH_LOG2:0]  count_o
);
    import fx3_pkg::*;

    localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

    gpif_word_t                 mem [DEPTH];
    logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
    logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
    logic [FIFO_DEPTH_LOG2:0]   count_q;
    logic                       push_ok;
    logic                       pop_ok;

    // ignore strobes that would overflow or underflow
    assign push_ok = push_i && (count_q != (FIFO_DEPTH_LOG2 + 1)'(DEPTH));
    assign pop_ok  = pop_i && (count_q != '0);

    always_ff @(posedge usb_clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_word_i;
        end
    end

    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_q <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // show-ahead head, a pop just moves past it
    assign pop_word_o = mem[rd_ptr];
    assign count_o    = count_q;

endmodule

`default_nettype wire

// ==== test/fx3_loopback_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module fx3_loopback_assert (
    input logic                usb_clk,
    input logic                reset_,
    input fx3_pkg::gpif_ctrl_t ctrl_i,
    input logic                data_oe_i
);
    int assert_fails = 0;

    // bus is either read or written in a cycle, never both
    rd_wr_exclusive: assert property (
        @(posedge usb_clk) disable iff (!reset_)
        !(!ctrl_i.slrd_n && !ctrl_i.slwr_n)
    ) else begin
        $error("slrd_n and slwr_n are low in the same cycle");
        assert_fails++;
    end

    // FX3 only drives the bus while sloe_n is low
    oe_during_read: assert property (
        @(posedge usb_clk) disable iff (!reset_)
        !ctrl_i.slrd_n |-> !ctrl_i.sloe_n
    ) else begin
        $error("slrd_n is low while sloe_n is high");
        assert_fails++;
    end

    // our data pins drive only on write cycles
    oe_matches_write: assert property (
        @(posedge usb_clk) disable iff (!reset_)
        data_oe_i == !ctrl_i.slwr_n
    ) else begin
        $error("data_oe_o does not follow slwr_n");
        assert_fails++;
    end

endmodule

bind fx3_loopback_top fx3_loopback_assert u_assert (
    .usb_clk   (usb_clk),
    .reset_    (reset_),
    .ctrl_i    (ctrl_o),
    .data_oe_i (data_oe_o)
);

`default_nettype wire

// ==== test/tb_fx3_loopback.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_fx3_loopback;
    import fx3_pkg::*;

    localparam int BURST       = 32;
    localparam int N_TESTS     = 5;
    localparam int CYCLE_NS    = 20;
    localparam int BURST_LIMIT = 3 * BURST + 60;
    localparam int WATCHDOG_NS = N_TESTS * BURST_LIMIT * CYCLE_NS;

    logic        usb_clk;
    logic        reset_;
    gpif_flags_t flags_i;
    gpif_word_t  data_i;
    gpif_ctrl_t  ctrl;
    gpif_word_t  data_out;
    logic        data_oe;

    logic [15:0] lfsr;
    gpif_word_t  sent_q[$];
    gpif_word_t  recv_q[$];
    int          rd_cycles;
    int          rd_runs;
    int          rd_bad_addr;
    int          wr_cycles;
    int          wr_bad;
    int          err_cnt;

    fx3_loopback_top #(
        .BURST_WORDS     (BURST),
        .FIFO_DEPTH_LOG2 (6)
    ) UUT (
        .usb_clk   (usb_clk),
        .reset_    (reset_),
        .flags_i   (flags_i),
        .data_i    (data_i),
        .ctrl_o    (ctrl),
        .data_o    (data_out),
        .data_oe_o (data_oe)
    );

    initial begin
        usb_clk = 1'b0;
        forever #(CYCLE_NS / 2) usb_clk = ~usb_clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("ERRORS FOUND");
        $finish;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per data bit
    task automatic draw_word(output gpif_word_t w);
        for (int i = 0; i < WORD_W; i++) begin
            w[i] = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // FX3 model watches the pins at +1 ns and drives the bus at +2 ns
    initial begin : fx3_model
        logic [RD_LATENCY-1:0] rd_hist;
        logic                  rd_now;
        logic                  rd_prev;
        logic                  word_due;
        gpif_word_t            word;
        rd_hist = '0;
        rd_prev = 1'b0;
        forever begin
            @(posedge usb_clk);
            #1;
            rd_now   = reset_ && !ctrl.slrd_n;
            word_due = rd_hist[RD_LATENCY-1];
            rd_hist  = {rd_hist[RD_LATENCY-2:0], rd_now};
            if (rd_now) begin
                rd_cycles++;
                if (!rd_prev) begin
                    rd_runs++;
                end
                if (ctrl.addr != ADDR_STREAM_OUT) begin
                    rd_bad_addr++;
                end
            end
            rd_prev = rd_now;
            // flag_b only paces writes and every write is accepted
            if (reset_ && !ctrl.slwr_n) begin
                wr_cycles++;
                recv_q.push_back(data_out);
                if (ctrl.addr != ADDR_STREAM_IN || !data_oe) begin
                    wr_bad++;
                end
            end
            #1;
            if (word_due) begin
                draw_word(word);
                sent_q.push_back(word);
                data_i = word;
            end else begin
                data_i = '0;
            end
        end
    end

    task automatic step_cycles(input int n);
        repeat (n) @(posedge usb_clk);
        #2;
    endtask

    task automatic report_mismatch(input string msg);
        $display("FAILED at %0t: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic set_flags(input logic a, input logic b, input logic c, input logic d);
        flags_i = '{flag_a: a, flag_b: b, flag_c: c, flag_d: d};
    endtask

    task automatic clear_model();
        sent_q.delete();
        recv_q.delete();
        rd_cycles   = 0;
        rd_runs     = 0;
        rd_bad_addr = 0;
        wr_cycles   = 0;
        wr_bad      = 0;
    endtask

    task automatic wait_for_count(input bit use_writes, input int target);
        int n;
        n = 0;
        while ((use_writes ? wr_cycles : rd_cycles) < target && n < BURST_LIMIT) begin
            step_cycles(1);
            n++;
        end
        if ((use_writes ? wr_cycles : rd_cycles) < target) begin
            $display("gave up at %0t waiting for %0d %s", $time, target,
                     use_writes ? "writes" : "reads");
            err_cnt++;
        end
    endtask

    // end of a transfer is slcs_n going back high
    task automatic wait_burst_end();
        int n;
        bit seen_busy;
        n         = 0;
        seen_busy = 1'b0;
        while (!(seen_busy && ctrl.slcs_n) && n < BURST_LIMIT) begin
            step_cycles(1);
            if (!ctrl.slcs_n) begin
                seen_busy = 1'b1;
            end
            n++;
        end
        if (!(seen_busy && ctrl.slcs_n)) begin
            $display("transfer did not finish within %0d cycles at %0t", BURST_LIMIT, $time);
            err_cnt++;
        end
    endtask

    task automatic compare_echo(input string tag);
        if (sent_q.size() != BURST || recv_q.size() != BURST) begin
            report_mismatch($sformatf("%s: sent %0d words, got %0d back, expected %0d",
                                      tag, sent_q.size(), recv_q.size(), BURST));
        end
        for (int i = 0; i < recv_q.size() && i < sent_q.size(); i++) begin
            if (recv_q[i] !== sent_q[i]) begin
                report_mismatch($sformatf("%s: word %0d is %h, expected %h",
                                          tag, i, recv_q[i], sent_q[i]));
            end
        end
        if (wr_bad != 0) begin
            report_mismatch($sformatf("%s: %0d writes with wrong addr or data_oe", tag, wr_bad));
        end
    endtask

    task automatic test_reset_state();
        set_flags(0, 0, 0, 0);
        for (int i = 0; i < 8; i++) begin
            step_cycles(1);
            if (!ctrl.slcs_n || !ctrl.slrd_n || !ctrl.sloe_n || !ctrl.slwr_n
                || ctrl.addr != ADDR_IDLE || data_oe) begin
                report_mismatch($sformatf("idle pins wrong, ctrl %b data_oe %b", ctrl, data_oe));
            end
        end
    endtask

    task automatic test_single_burst();
        clear_model();
        set_flags(1, 1, 1, 1);
        wait_for_count(0, 1);
        set_flags(1, 1, 0, 0);
        wait_burst_end();
        if (rd_cycles != BURST || rd_runs != 1) begin
            report_mismatch($sformatf("%0d slrd_n-low cycles in %0d runs, expected %0d in 1",
                                      rd_cycles, rd_runs, BURST));
        end
        if (rd_bad_addr != 0) begin
            report_mismatch($sformatf("%0d reads outside ADDR_STREAM_OUT", rd_bad_addr));
        end
        compare_echo("single burst");
    endtask

    task automatic test_write_hold();
        clear_model();
        set_flags(0, 0, 1, 1);
        wait_for_count(0, 1);
        set_flags(0, 0, 0, 0);
        wait_for_count(0, BURST);
        // give the last reads time to land in the FIFO
        step_cycles(12);
        if (wr_cycles != 0 || ctrl.slcs_n) begin
            report_mismatch($sformatf("%0d writes with flag_a and flag_b low", wr_cycles));
        end
        set_flags(0, 1, 0, 0);
        step_cycles(10);
        if (wr_cycles != 0) begin
            report_mismatch($sformatf("%0d writes with only flag_b high", wr_cycles));
        end
        set_flags(1, 0, 0, 0);
        step_cycles(10);
        if (wr_cycles != 0) begin
            report_mismatch($sformatf("%0d writes with only flag_a high", wr_cycles));
        end
        set_flags(1, 1, 0, 0);
        wait_burst_end();
        compare_echo("held write");
    endtask

    task automatic test_write_pause();
        int at_drop;
        clear_model();
        set_flags(1, 1, 1, 1);
        wait_for_count(0, 1);
        set_flags(1, 1, 0, 0);
        wait_for_count(1, 8);
        at_drop = wr_cycles;
        set_flags(1, 0, 0, 0);
        step_cycles(10);
        if (wr_cycles - at_drop > 3) begin
            report_mismatch($sformatf("%0d writes after flag_b fell, at most 3 allowed",
                                      wr_cycles - at_drop));
        end
        set_flags(1, 1, 0, 0);
        wait_burst_end();
        compare_echo("paused write");
    endtask

    // stream-out flags stay high so the second burst follows at once
    task automatic test_back_to_back();
        clear_model();
        set_flags(1, 1, 1, 1);
        wait_burst_end();
        compare_echo("first burst");
        clear_model();
        wait_for_count(0, 1);
        set_flags(1, 1, 0, 0);
        wait_burst_end();
        compare_echo("second burst");
    endtask

    initial begin
        flags_i   = '0;
        data_i    = '0;
        reset_    = 1'b0;
        lfsr      = 16'd9159;
        err_cnt   = 0;
        clear_model();
        repeat (5) @(posedge usb_clk);
        #2;
        reset_ = 1'b1;

        test_reset_state();
        test_single_burst();
        test_write_hold();
        test_write_pause();
        test_back_to_back();

        step_cycles(4);
        err_cnt = err_cnt + UUT.u_assert.assert_fails;
        $display("tests run: %0d, errors: %0d", N_TESTS, err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/fx3_pkg.sv
logic/gpif_capture.sv
logic/word_fifo.sv
logic/transfer_sequencer.sv
logic/gpif_drive.sv
logic/fx3_loopback_top.sv
test/fx3_loopback_assert.sv
test/tb_fx3_loopback.sv
